/* source/riscv_defines.svh */
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// Data path and address width.
`define RV_XLEN 32

// Architectural register count, x0 included.
`define RV_NREGS 32

// Memory depths in 32-bit words.
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256

`endif

/* source/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

    // ########################################################################
    // Major opcodes of the supported RV32I subset
    // ########################################################################
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_OP,
        CLS_OP_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_LUI,
        CLS_ILLEGAL
    } instr_class_e;

    // One bit per state.
    typedef enum logic [5:0] {
        S_FETCH     = 6'b000001,
        S_DECODE    = 6'b000010,
        S_EXECUTE   = 6'b000100,
        S_MEMORY    = 6'b001000,
        S_WRITEBACK = 6'b010000,
        S_HALT      = 6'b100000
    } ctrl_state_e;

endpackage

`default_nettype wire

/* source/riscv_ifs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "riscv_defines.svh"

interface alu_if;
    riscv_pkg::alu_op_e  op;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] result;
    logic                zero;   // Registered a == b.

    modport master (output op, a, b, input result, zero);
    modport self   (input op, a, b, output result, zero);
endinterface

interface idecoder_if;
    logic [31:0]                   instr;
    riscv_pkg::instr_class_e       cls;
    riscv_pkg::alu_op_e            alu_op;
    logic [$clog2(`RV_NREGS)-1:0]  rs1;
    logic [$clog2(`RV_NREGS)-1:0]  rs2;
    logic [$clog2(`RV_NREGS)-1:0]  rd;
    logic [`RV_XLEN-1:0]           imm;
    logic                          use_imm;
    logic                          branch_ne;

    modport master (output instr, input cls, alu_op, rs1, rs2, rd, imm, use_imm, branch_ne);
    modport self   (input instr, output cls, alu_op, rs1, rs2, rd, imm, use_imm, branch_ne);
endinterface

interface reg_file_if;
    logic [$clog2(`RV_NREGS)-1:0] raddr1;
    logic [$clog2(`RV_NREGS)-1:0] raddr2;
    logic                         we;
    logic [$clog2(`RV_NREGS)-1:0] waddr;
    logic [`RV_XLEN-1:0]          wdata;
    logic [`RV_XLEN-1:0]          rdata1;
    logic [`RV_XLEN-1:0]          rdata2;

    modport master (output raddr1, raddr2, we, waddr, wdata, input rdata1, rdata2);
    modport self   (input raddr1, raddr2, we, waddr, wdata, output rdata1, rdata2);
endinterface

// Word-addressed memory port. Read data follows en by one cycle.
interface mem_if;
    logic                en;
    logic                we;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
    logic [`RV_XLEN-1:0] rdata;

    modport master (output en, we, addr, wdata, input rdata);
    modport self   (input en, we, addr, wdata, output rdata);
endinterface

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "riscv_defines.svh"

module alu (
    input wire         clk,
    input wire         arst_n,
    alu_if.self        alu_if
);

    logic [`RV_XLEN-1:0] res;
    logic                lt;

    assign lt = $signed(alu_if.a) < $signed(alu_if.b);

    always_comb begin
        unique case (alu_if.op)
            riscv_pkg::ALU_ADD: res = alu_if.a + alu_if.b;
            riscv_pkg::ALU_SUB: res = alu_if.a - alu_if.b;
            riscv_pkg::ALU_AND: res = alu_if.a & alu_if.b;
            riscv_pkg::ALU_OR:  res = alu_if.a | alu_if.b;
            riscv_pkg::ALU_XOR: res = alu_if.a ^ alu_if.b;
            riscv_pkg::ALU_SLT: res = {{(`RV_XLEN-1){1'b0}}, lt};
            default:            res = alu_if.b;   // PASS_B for LUI.
        endcase
    end

    // Result and branch flag appear one cycle after the operands.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_if.result <= '0;
            alu_if.zero   <= 1'b0;
        end else begin
            alu_if.result <= res;
            alu_if.zero   <= (alu_if.a == alu_if.b);
        end
    end

endmodule

`default_nettype wire

/* source/idecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module idecoder (
    idecoder_if.self idecoder_if
);

    logic [31:0] ins;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;

    assign ins    = idecoder_if.instr;
    assign opcode = ins[6:0];
    assign funct3 = ins[14:12];
    assign funct7 = ins[31:25];

    assign idecoder_if.rs1       = ins[19:15];
    assign idecoder_if.rs2       = ins[24:20];
    assign idecoder_if.rd        = ins[11:7];
    assign idecoder_if.branch_ne = funct3[0];   // BNE is funct3 001.

    always_comb begin
        idecoder_if.cls     = riscv_pkg::CLS_ILLEGAL;
        idecoder_if.alu_op  = riscv_pkg::ALU_ADD;
        idecoder_if.use_imm = 1'b1;
        idecoder_if.imm     = {{20{ins[31]}}, ins[31:20]};   // I-type unless noted.
        unique case (opcode)
            riscv_pkg::OPC_OP, riscv_pkg::OPC_OP_IMM: begin
                idecoder_if.use_imm = (opcode == riscv_pkg::OPC_OP_IMM);
                idecoder_if.cls     = (opcode == riscv_pkg::OPC_OP) ? riscv_pkg::CLS_OP
                                                                    : riscv_pkg::CLS_OP_IMM;
                case (funct3)
                    3'b000: idecoder_if.alu_op = riscv_pkg::ALU_ADD;
                    3'b010: idecoder_if.alu_op = riscv_pkg::ALU_SLT;
                    3'b100: idecoder_if.alu_op = riscv_pkg::ALU_XOR;
                    3'b110: idecoder_if.alu_op = riscv_pkg::ALU_OR;
                    3'b111: idecoder_if.alu_op = riscv_pkg::ALU_AND;
                    default: idecoder_if.cls   = riscv_pkg::CLS_ILLEGAL;
                endcase
                // Register forms allow funct7 of zero, or SUB on ADD's funct3.
                if (opcode == riscv_pkg::OPC_OP) begin
                    if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                        idecoder_if.alu_op = riscv_pkg::ALU_SUB;
                    end else if (funct7 != 7'b0000000) begin
                        idecoder_if.cls = riscv_pkg::CLS_ILLEGAL;
                    end
                end
            end
            riscv_pkg::OPC_LOAD: begin
                if (funct3 == 3'b010) idecoder_if.cls = riscv_pkg::CLS_LOAD;   // LW only.
            end
            riscv_pkg::OPC_STORE: begin
                idecoder_if.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                if (funct3 == 3'b010) idecoder_if.cls = riscv_pkg::CLS_STORE;
            end
            riscv_pkg::OPC_BRANCH: begin
                idecoder_if.use_imm = 1'b0;
                idecoder_if.alu_op  = riscv_pkg::ALU_SUB;
                idecoder_if.imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                if (funct3[2:1] == 2'b00) idecoder_if.cls = riscv_pkg::CLS_BRANCH;
            end
            riscv_pkg::OPC_JAL: begin
                idecoder_if.cls = riscv_pkg::CLS_JAL;
                idecoder_if.imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            riscv_pkg::OPC_LUI: begin
                idecoder_if.cls    = riscv_pkg::CLS_LUI;
                idecoder_if.alu_op = riscv_pkg::ALU_PASS_B;
                idecoder_if.imm    = {ins[31:12], 12'b0};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "riscv_defines.svh"

module reg_file (
    input wire         clk,
    input wire         arst_n,
    reg_file_if.self   reg_file_if
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (reg_file_if.we && reg_file_if.waddr != '0) begin
            regs[reg_file_if.waddr] <= reg_file_if.wdata;
        end
    end

    // x0 is hardwired, whatever the array holds.
    assign reg_file_if.rdata1 = (reg_file_if.raddr1 == '0) ? '0 : regs[reg_file_if.raddr1];
    assign reg_file_if.rdata2 = (reg_file_if.raddr2 == '0) ? '0 : regs[reg_file_if.raddr2];

endmodule

`default_nettype wire

/* source/word_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "riscv_defines.svh"

module word_mem #(
    parameter int DEPTH = 256
) (
    input wire     clk,
    mem_if.self    mem_if
);

    localparam int AW = $clog2(DEPTH);

    logic [`RV_XLEN-1:0] mem [DEPTH];
    logic [AW-1:0]       idx;

    assign idx = mem_if.addr[AW-1:0];   // Word index, upper bits ignored.

    // Read before write on a shared cycle.
    always_ff @(posedge clk) begin
        if (mem_if.en) begin
            if (mem_if.we) begin
                mem[idx] <= mem_if.wdata;
            end
            mem_if.rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

/* source/control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "riscv_defines.svh"

module control_unit (
    input wire                             clk,
    input wire                             arst_n,
    alu_if.master                          alu_if,
    idecoder_if.master                     idecoder_if,
    reg_file_if.master                     reg_file_if,
    mem_if.master                          imem,
    mem_if.master                          dmem,
    output logic [`RV_XLEN-1:0]            pc,
    output logic [31:0]                    instr,
    output logic                           retire,
    output logic [$clog2(`RV_NREGS)-1:0]   retire_rd,
    output logic [`RV_XLEN-1:0]            retire_data,
    output logic                           halted
);

    riscv_pkg::ctrl_state_e  state;
    riscv_pkg::ctrl_state_e  state_nxt;
    riscv_pkg::instr_class_e cls;
    logic                    writes_rd;
    logic                    taken;
    logic [`RV_XLEN-1:0]     wb_data;

    assign cls       = idecoder_if.cls;
    assign writes_rd = cls inside {riscv_pkg::CLS_OP, riscv_pkg::CLS_OP_IMM, riscv_pkg::CLS_LOAD,
                                   riscv_pkg::CLS_JAL, riscv_pkg::CLS_LUI};
    assign taken     = (cls == riscv_pkg::CLS_JAL) ||
                       (cls == riscv_pkg::CLS_BRANCH && (alu_if.zero != idecoder_if.branch_ne));
    assign wb_data   = (cls == riscv_pkg::CLS_LOAD) ? dmem.rdata : alu_if.result;
    assign halted    = (state == riscv_pkg::S_HALT);

    assign idecoder_if.instr = instr;

    // ########################################################################
    // Block hookup
    // ########################################################################
    assign imem.en    = (state == riscv_pkg::S_FETCH);   // Word arrives in DECODE.
    assign imem.we    = 1'b0;
    assign imem.addr  = {2'b00, pc[`RV_XLEN-1:2]};
    assign imem.wdata = '0;

    // JAL runs pc + 4 through the ALU as its link value.
    assign alu_if.op = idecoder_if.alu_op;
    assign alu_if.a  = (cls == riscv_pkg::CLS_JAL) ? pc : reg_file_if.rdata1;
    assign alu_if.b  = (cls == riscv_pkg::CLS_JAL) ? `RV_XLEN'd4 :
                       idecoder_if.use_imm ? idecoder_if.imm : reg_file_if.rdata2;

    assign reg_file_if.raddr1 = idecoder_if.rs1;
    assign reg_file_if.raddr2 = idecoder_if.rs2;
    assign reg_file_if.we     = (state == riscv_pkg::S_WRITEBACK) && writes_rd;
    assign reg_file_if.waddr  = idecoder_if.rd;
    assign reg_file_if.wdata  = wb_data;

    assign dmem.en    = (state == riscv_pkg::S_MEMORY);
    assign dmem.we    = (state == riscv_pkg::S_MEMORY) && (cls == riscv_pkg::CLS_STORE);
    assign dmem.addr  = {2'b00, alu_if.result[`RV_XLEN-1:2]};
    assign dmem.wdata = reg_file_if.rdata2;

    // ########################################################################
    // Sequencing
    // ########################################################################
    always_comb begin
        unique case (state)
            riscv_pkg::S_FETCH:  state_nxt = riscv_pkg::S_DECODE;
            riscv_pkg::S_DECODE: state_nxt = riscv_pkg::S_EXECUTE;
            riscv_pkg::S_EXECUTE: begin
                if (cls == riscv_pkg::CLS_ILLEGAL) begin
                    state_nxt = riscv_pkg::S_HALT;
                end else if (cls inside {riscv_pkg::CLS_LOAD, riscv_pkg::CLS_STORE}) begin
                    state_nxt = riscv_pkg::S_MEMORY;
                end else begin
                    state_nxt = riscv_pkg::S_WRITEBACK;
                end
            end
            riscv_pkg::S_MEMORY:    state_nxt = riscv_pkg::S_WRITEBACK;
            riscv_pkg::S_WRITEBACK: state_nxt = riscv_pkg::S_FETCH;
            default:                state_nxt = riscv_pkg::S_HALT;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= riscv_pkg::S_FETCH;
            pc          <= '0;
            instr       <= '0;
            retire      <= 1'b0;
            retire_rd   <= '0;
            retire_data <= '0;
        end else begin
            state  <= state_nxt;
            retire <= (state == riscv_pkg::S_WRITEBACK);   // High in the next FETCH.
            if (state == riscv_pkg::S_DECODE) begin
                instr <= imem.rdata;
            end
            if (state == riscv_pkg::S_WRITEBACK) begin
                pc          <= taken ? pc + idecoder_if.imm : pc + `RV_XLEN'd4;
                retire_rd   <= writes_rd ? idecoder_if.rd : '0;
                retire_data <= writes_rd ? wb_data : '0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/riscv_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "riscv_defines.svh"

module riscv_core (
    input wire                             clk,
    input wire                             arst_n,
    input wire                             prog_we,
    input wire [`RV_XLEN-1:0]              prog_addr,
    input wire [`RV_XLEN-1:0]              prog_data,
    output logic [31:0]                    instruction,
    output logic [`RV_XLEN-1:0]            pc,
    output logic                           retire,
    output logic [$clog2(`RV_NREGS)-1:0]   retire_rd,
    output logic [`RV_XLEN-1:0]            retire_data,
    output logic                           halted
);

    alu_if      alu_if();
    idecoder_if idecoder_if();
    reg_file_if reg_file_if();
    mem_if      imem_fetch();
    mem_if      imem_bus();
    mem_if      dmem_bus();

    // The loader owns the instruction memory port while reset is held.
    assign imem_bus.en      = arst_n ? imem_fetch.en    : prog_we;
    assign imem_bus.we      = arst_n ? imem_fetch.we    : prog_we;
    assign imem_bus.addr    = arst_n ? imem_fetch.addr  : prog_addr;
    assign imem_bus.wdata   = arst_n ? imem_fetch.wdata : prog_data;
    assign imem_fetch.rdata = imem_bus.rdata;

    control_unit u_control_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .alu_if      (alu_if.master),
        .idecoder_if (idecoder_if.master),
        .reg_file_if (reg_file_if.master),
        .imem        (imem_fetch.master),
        .dmem        (dmem_bus.master),
        .pc          (pc),
        .instr       (instruction),
        .retire      (retire),
        .retire_rd   (retire_rd),
        .retire_data (retire_data),
        .halted      (halted)
    );

    alu u_alu (
        .clk    (clk),
        .arst_n (arst_n),
        .alu_if (alu_if.self)
    );

    idecoder u_idecoder (
        .idecoder_if (idecoder_if.self)
    );

    reg_file u_reg_file (
        .clk         (clk),
        .arst_n      (arst_n),
        .reg_file_if (reg_file_if.self)
    );

    word_mem #(.DEPTH(`RV_IMEM_WORDS)) u_imem (
        .clk    (clk),
        .mem_if (imem_bus.self)
    );

    word_mem #(.DEPTH(`RV_DMEM_WORDS)) u_dmem (
        .clk    (clk),
        .mem_if (dmem_bus.self)
    );

endmodule

`default_nettype wire

/* test/riscv_core_props.sv */
`timescale 1ns/1ns
`default_nettype none

module riscv_core_props (
    input wire        clk,
    input wire        arst_n,
    input wire [5:0]  state,
    input wire [31:0] pc,
    input wire        retire,
    input wire        halted,
    input wire        dmem_we
);

    // ########################################################################
    // Control unit rules
    // ########################################################################
    state_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot(state))
        else $error("Control state %b is not one-hot.", state);

    quiet_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> (!retire && !dmem_we))
        else $error("Retire pulse or data memory write while the core is halted.");

    halt_is_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted)
        else $error("The halted level dropped without a reset.");

    pc_word_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
        else $error("Program counter %h is not word aligned.", pc);

    // Retire lands 4 cycles after FETCH, 5 when MEMORY is visited, never for a halt.
    retire_after_fetch: assert property (@(posedge clk) disable iff (!arst_n)
        (state == riscv_pkg::S_FETCH) |-> ##1 (!retire) [*3]
            ##1 (retire or (state == riscv_pkg::S_WRITEBACK ##1 retire) or halted))
        else $error("Retire did not follow FETCH by exactly 4 or 5 cycles.");

endmodule

bind control_unit riscv_core_props u_props (
    .clk     (clk),
    .arst_n  (arst_n),
    .state   (state),
    .pc      (pc),
    .retire  (retire),
    .halted  (halted),
    .dmem_we (dmem.we)
);

`default_nettype wire

/* test/riscv_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "riscv_defines.svh"

module riscv_core_tb;

    localparam logic [6:0] OPI = 7'b0010011;

    typedef struct {
        string       name;
        logic [31:0] word;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] npc;
        bit          mem;
    } retire_rec_t;

    logic                clk;
    logic                arst_n;
    logic                prog_we;
    logic [`RV_XLEN-1:0] prog_addr;
    logic [`RV_XLEN-1:0] prog_data;
    wire  [31:0]         instruction;
    wire  [`RV_XLEN-1:0] pc;
    wire                 retire;
    wire  [4:0]          retire_rd;
    wire  [`RV_XLEN-1:0] retire_data;
    wire                 halted;

    logic [31:0] prog [64];
    logic [31:0] xr [32];      // Model register file.
    logic [31:0] dm [256];     // Model data memory, word indexed.
    retire_rec_t recs [$];
    int          nwords = 0;
    int          idx = 0;
    int          cyc = 0;
    int          last_cyc = 1; // First FETCH falls on cycle 1.
    int          limit = 0;
    int          seed = 12;

    riscv_core u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(string test, string field, logic [31:0] exp, logic [31:0] act);
        abort_run($sformatf("[ERROR] %s %s expected %h actual %h", test, field, exp, act));
    endtask

    // ########################################################################
    // Encoders and the reference model
    // ########################################################################
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Kinds 0 to 4 are immediate forms, 5 to 10 register forms.
    function automatic logic [31:0] model_op(int kind, logic [31:0] a, logic [31:0] b);
        case (kind)
            0, 5:    return a + b;
            6:       return a - b;
            1, 7:    return a & b;
            2, 8:    return a | b;
            3, 9:    return a ^ b;
            default: return {31'b0, $signed(a) < $signed(b)};
        endcase
    endfunction

    function automatic logic [2:0] funct3_of(int kind);
        case (kind)
            0, 5, 6: return 3'b000;
            1, 7:    return 3'b111;
            2, 8:    return 3'b110;
            3, 9:    return 3'b100;
            default: return 3'b010;
        endcase
    endfunction

    task automatic write_reg(logic [4:0] rd, logic [31:0] val);
        if (rd != 5'd0) xr[rd] = val;
    endtask

    // Places a word and, for a retiring one, the record the model predicts for it.
    task automatic issue(string name, logic [31:0] word, logic [4:0] rd, logic [31:0] data,
                         int step, bit mem);
        recs.push_back('{name, word, rd, data, 32'(4 * nwords + step), mem});
        prog[nwords] = word;
        nwords++;
    endtask

    task automatic build_program();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] res;
        logic [31:0] word;
        foreach (xr[r]) xr[r] = '0;
        for (int i = 0; i < 40; i++) begin
            kind = int'(32'($random(seed)) % 32'd12);
            rd   = 5'($random(seed) & 7);
            rs1  = 5'($random(seed) & 7);
            rs2  = 5'($random(seed) & 7);
            imm  = 12'($random(seed));
            if (kind == 11) begin
                res  = {20'($random(seed)), 12'b0};
                word = {res[31:12], rd, 7'b0110111};
            end else if (kind < 5) begin
                res  = model_op(kind, xr[rs1], {{20{imm[11]}}, imm});
                word = enc_i(OPI, funct3_of(kind), rd, rs1, imm);
            end else begin
                res  = model_op(kind, xr[rs1], xr[rs2]);
                word = enc_r((kind == 6) ? 7'b0100000 : 7'b0, funct3_of(kind), rd, rs1, rs2);
            end
            issue($sformatf("alu_%0d", i), word, rd, res, 4, 1'b0);
            write_reg(rd, res);
        end
        // The x0 write is reported with its value but leaves x0 at zero.
        issue("x0_write", enc_i(OPI, 3'b000, 5'd0, 5'd1, 12'd77), 5'd0, xr[1] + 32'd77, 4, 1'b0);
        issue("x0_read", enc_r(7'b0, 3'b000, 5'd9, 5'd0, 5'd0), 5'd9, 32'd0, 4, 1'b0);
        write_reg(5'd9, 32'd0);
        issue("lui_x3", {20'h12345, 5'd3, 7'b0110111}, 5'd3, 32'h12345000, 4, 1'b0);
        write_reg(5'd3, 32'h12345000);
        issue("addi_x4", enc_i(OPI, 3'b000, 5'd4, 5'd0, 12'hffd), 5'd4, 32'hfffffffd, 4, 1'b0);
        write_reg(5'd4, 32'hfffffffd);
        // Here -3 < 0 holds only when the compare is signed.
        issue("slt_signed", enc_r(7'b0, 3'b010, 5'd5, 5'd4, 5'd0), 5'd5, 32'd1, 4, 1'b0);
        write_reg(5'd5, 32'd1);
        issue("addi_base", enc_i(OPI, 3'b000, 5'd10, 5'd0, 12'd64), 5'd10, 32'd64, 4, 1'b0);
        write_reg(5'd10, 32'd64);

        // ####################################################################
        // Stores, loads and control flow
        // ####################################################################
        issue("sw_0", enc_s(5'd10, 5'd3, 12'd0), 5'd0, 32'd0, 4, 1'b1);
        dm[8'(xr[10] >> 2)] = xr[3];
        issue("sw_8", enc_s(5'd10, 5'd4, 12'd8), 5'd0, 32'd0, 4, 1'b1);
        dm[8'((xr[10] + 32'd8) >> 2)] = xr[4];
        res = dm[8'(xr[10] >> 2)];
        issue("lw_0", enc_i(7'b0000011, 3'b010, 5'd11, 5'd10, 12'd0), 5'd11, res, 4, 1'b1);
        write_reg(5'd11, res);
        res = dm[8'((xr[10] + 32'd8) >> 2)];
        issue("lw_8", enc_i(7'b0000011, 3'b010, 5'd12, 5'd10, 12'd8), 5'd12, res, 4, 1'b1);
        write_reg(5'd12, res);
        issue("beq_taken", enc_b(3'b000, 5'd11, 5'd3, 13'd8), 5'd0, 32'd0, 8, 1'b0);
        prog[nwords++] = enc_i(OPI, 3'b000, 5'd13, 5'd0, 12'd1);   // Skipped.
        issue("bne_not_taken", enc_b(3'b001, 5'd11, 5'd3, 13'd8), 5'd0, 32'd0, 4, 1'b0);
        res = 32'(4 * nwords + 4);
        issue("jal", enc_j(5'd1, 21'd8), 5'd1, res, 8, 1'b0);
        write_reg(5'd1, res);
        prog[nwords++] = enc_i(OPI, 3'b000, 5'd13, 5'd0, 12'd2);   // Skipped.
        issue("jal_link", enc_i(OPI, 3'b000, 5'd15, 5'd1, 12'd0), 5'd15, xr[1], 4, 1'b0);
        prog[nwords++] = 32'hffffffff;
    endtask

    task automatic check_retire();
        int gap;
        gap      = cyc - last_cyc;
        last_cyc = cyc;
        assert (idx < recs.size()) else abort_run("A retire pulse came after the last instruction.");
        assert (instruction == recs[idx].word)
            else report_mismatch(recs[idx].name, "instruction", recs[idx].word, instruction);
        assert (retire_rd == recs[idx].rd)
            else report_mismatch(recs[idx].name, "retire_rd", 32'(recs[idx].rd), 32'(retire_rd));
        assert (retire_data == recs[idx].data)
            else report_mismatch(recs[idx].name, "retire_data", recs[idx].data, retire_data);
        assert (pc == recs[idx].npc)
            else report_mismatch(recs[idx].name, "pc", recs[idx].npc, pc);
        assert (gap == (recs[idx].mem ? 5 : 4))
            else report_mismatch(recs[idx].name, "retire_gap", recs[idx].mem ? 5 : 4, gap);
        idx++;
    endtask

    // Outputs change on the rising edge and are sampled on the falling one.
    always @(negedge clk) begin
        if (arst_n) begin
            cyc = cyc + 1;
            if (cyc > limit) begin
                abort_run($sformatf("Timeout: the core did not halt within %0d cycles.", limit));
            end else if (retire && halted) begin
                abort_run("The core retired an instruction while halted.");
            end else if (retire) begin
                check_retire();
            end
        end
    end

    initial begin
        arst_n    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        build_program();
        limit = 5 * nwords + 50;
        for (int i = 0; i < nwords; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= i;
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        while (!halted) @(negedge clk);
        assert (idx == recs.size())
            else report_mismatch("halt", "retired_count", recs.size(), idx);
        repeat (8) @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* riscv_core.f */
+incdir+source
source/riscv_pkg.sv
source/riscv_ifs.sv
source/alu.sv
source/idecoder.sv
source/reg_file.sv
source/word_mem.sv
source/control_unit.sv
source/riscv_core.sv
test/riscv_core_props.sv
test/riscv_core_tb.sv

/* Bender.yml */
package:
  name: riscv_core

sources:
  - include_dirs:
      - source
    files:
      - source/riscv_pkg.sv
      - source/riscv_ifs.sv
      - source/alu.sv
      - source/idecoder.sv
      - source/reg_file.sv
      - source/word_mem.sv
      - source/control_unit.sv
      - source/riscv_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/riscv_core_props.sv
      - test/riscv_core_tb.sv
